// ==== src.f ====
hdl/dma_axi_pkg.sv
hdl/dma_cfg_pkg.sv
hdl/dmac_ctrl.sv
hdl/dmac_read.sv
hdl/dmac_write.sv
hdl/dmac_top.sv
dv/axi_mem_model.sv
dv/tb_dmac.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP      = tb_dmac
FILELIST = src.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/tb_dmac.sv ====
`default_nettype none

module tb_dmac
    import dma_axi_pkg::*;
    import dma_cfg_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_BEATS      = 16;
    localparam int TIMEOUT_CYCLES = 40 * 16 * 20;

    logic       clk_i;
    logic       rst_ni;
    logic       start_i;
    dma_desc_t  desc_i;
    logic       busy_o;
    logic       done_o;
    logic       err_o;
    axi_ar_t    ar_o;
    logic       ar_valid_o;
    logic       ar_ready_i;
    axi_r_t     r_i;
    logic       r_valid_i;
    logic       r_ready_o;
    axi_aw_t    aw_o;
    logic       aw_valid_o;
    logic       aw_ready_i;
    axi_w_t     w_o;
    logic       w_valid_o;
    logic       w_ready_i;
    axi_b_t     b_i;
    logic       b_valid_i;
    logic       b_ready_o;
    logic [3:0] ar_id_log;
    logic [3:0] aw_id_log;
    int         aw_count;

    logic [31:0] ref_mem [0:65535];             // Expected memory contents.
    int          checks     = 0;
    int          errors     = 0;
    int          done_count = 0;
    int          cycles     = 0;
    logic [3:0]  id_region [3] = '{4'h0, 4'h2, 4'h5};
    logic [3:0]  id_expect [3] = '{4'h1, 4'h2, 4'h0};

    dmac_top #(.NUM_BEATS(NUM_BEATS)) dut (.*);

    axi_mem_model u_mem (
        .clk_i      (clk_i),
        .ar_i       (ar_o),
        .ar_valid_i (ar_valid_o),
        .ar_ready_o (ar_ready_i),
        .r_o        (r_i),
        .r_valid_o  (r_valid_i),
        .r_ready_i  (r_ready_o),
        .aw_i       (aw_o),
        .aw_valid_i (aw_valid_o),
        .aw_ready_o (aw_ready_i),
        .w_i        (w_o),
        .w_valid_i  (w_valid_o),
        .w_ready_o  (w_ready_i),
        .b_o        (b_i),
        .b_valid_o  (b_valid_i),
        .b_ready_i  (b_ready_o),
        .ar_id_o    (ar_id_log),
        .aw_id_o    (aw_id_log),
        .aw_count_o (aw_count)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    always @(negedge clk_i) begin
        if (rst_ni && done_o) begin
            done_count++;
        end
    end

    initial begin : watchdog
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("Timeout: the test did not finish within %0d cycles", cycles);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("STATUS: FAIL");
        $finish;
    end

    // ==================================================
    // Helpers
    // ==================================================
    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s at %0t: got %h, expected %h", name, $time, got, exp);
        end
    endtask

    task automatic idle_outputs_low();
        compare_value("busy_o", 32'(busy_o), 32'd0);
        compare_value("done_o", 32'(done_o), 32'd0);
        compare_value("ar_valid_o", 32'(ar_valid_o), 32'd0);
        compare_value("r_ready_o", 32'(r_ready_o), 32'd0);
        compare_value("aw_valid_o", 32'(aw_valid_o), 32'd0);
        compare_value("w_valid_o", 32'(w_valid_o), 32'd0);
        compare_value("b_ready_o", 32'(b_ready_o), 32'd0);
    endtask

    function automatic dma_desc_t random_desc(input logic [1:0] burst,
                                              input logic [3:0] src_region,
                                              input logic [3:0] dst_region);
        dma_desc_t d;
        d.src_addr = {12'h000, src_region, 14'($urandom_range(0, 16383)), 2'b00};
        d.dst_addr = {12'h000, dst_region, 14'($urandom_range(0, 16383)), 2'b00};
        d.len      = 8'($urandom_range(0, NUM_BEATS - 1));
        d.burst    = burst;
        return d;
    endfunction

    function automatic logic [15:0] beat_index(input logic [31:0] base, input int beat,
                                               input logic [1:0] burst);
        logic [31:0] addr;
        addr = (burst == BURST_FIXED) ? base : base + 32'(4 * beat);
        return addr[17:2];
    endfunction

    task automatic start_transfer(input dma_desc_t d);
        desc_i  = d;
        start_i = 1'b1;
        @(posedge clk_i);
        #1;
        start_i = 1'b0;
    endtask

    task automatic wait_for_done(output logic got_err);
        while (done_o !== 1'b1) begin
            @(posedge clk_i);
            #1;
        end
        got_err = err_o;                        // Valid with done.
    endtask

    // Whole burst is read before any write, so overlap is safe.
    task automatic apply_copy(input dma_desc_t d);
        logic [31:0] buffer [NUM_BEATS];
        for (int i = 0; i <= int'(d.len); i++) begin
            buffer[i] = ref_mem[beat_index(d.src_addr, i, d.burst)];
        end
        for (int i = 0; i <= int'(d.len); i++) begin
            ref_mem[beat_index(d.dst_addr, i, d.burst)] = buffer[i];
        end
    endtask

    // Destination words plus one neighbor on each side.
    task automatic verify_dst_words(input dma_desc_t d);
        int          span;
        logic [15:0] idx;
        span = (d.burst == BURST_FIXED) ? 1 : int'(d.len) + 1;
        for (int i = -1; i <= span; i++) begin
            idx = d.dst_addr[17:2] + 16'(i);
            compare_value($sformatf("mem[%h]", idx), u_mem.mem[idx], ref_mem[idx]);
        end
    endtask

    task automatic run_and_check(input dma_desc_t d, input logic exp_err);
        logic got_err;
        start_transfer(d);
        wait_for_done(got_err);
        compare_value("err_o", 32'(got_err), 32'(exp_err));
        apply_copy(d);
        verify_dst_words(d);
    endtask

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin : main
        dma_desc_t   d;
        dma_desc_t   d2;
        logic [31:0] word;
        logic        got_err;
        int          done_before;
        int          aw_before;
        void'($urandom(38));
        rst_ni  = 1'b0;
        start_i = 1'b0;
        desc_i  = '0;
        for (int i = 0; i < 65536; i++) begin
            word         = $urandom;
            u_mem.mem[i] = word;
            ref_mem[i]   = word;
        end

        repeat (5) begin
            @(posedge clk_i);
            #1;
            idle_outputs_low();
        end
        rst_ni = 1'b1;
        @(posedge clk_i);
        #1;
        idle_outputs_low();

        for (int n = 0; n < 30; n++) begin
            run_and_check(random_desc(BURST_INCR, 4'h0, 4'h0), 1'b0);
        end

        d     = random_desc(BURST_FIXED, 4'h0, 4'h0);
        d.len = 8'd3;
        run_and_check(d, 1'b0);

        for (int k = 0; k < 3; k++) begin
            run_and_check(random_desc(BURST_INCR, id_region[k], id_region[(k + 1) % 3]), 1'b0);
            compare_value("ar_o.id", 32'(ar_id_log), 32'(id_expect[k]));
            compare_value("aw_o.id", 32'(aw_id_log), 32'(id_expect[(k + 1) % 3]));
        end

        d                 = random_desc(BURST_INCR, 4'hF, 4'h0);
        d.src_addr[15:12] = 4'hF;               // First beat lands in the error window.
        run_and_check(d, 1'b1);
        run_and_check(random_desc(BURST_INCR, 4'h0, 4'h0), 1'b0);

        // Second start arrives while the first transfer is running.
        d         = random_desc(BURST_INCR, 4'h0, 4'h0);
        d.len     = 8'(NUM_BEATS - 1);
        d2        = random_desc(BURST_INCR, 4'h0, 4'h3);
        aw_before = aw_count;
        start_transfer(d);
        done_before = done_count;               // Previous done strobe is counted by now.
        checks++;
        if (busy_o !== 1'b1) begin
            errors++;
            $display("busy_o was low when the second start was pulsed");
        end
        start_transfer(d2);
        wait_for_done(got_err);
        compare_value("err_o", 32'(got_err), 32'd0);
        apply_copy(d);
        verify_dst_words(d);
        repeat (200) @(posedge clk_i);
        #1;
        compare_value("done_o count", 32'(done_count - done_before), 32'd1);
        compare_value("AW count", 32'(aw_count - aw_before), 32'd1);
        verify_dst_words(d2);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/axi_mem_model.sv ====
`default_nettype none

module axi_mem_model
    import dma_axi_pkg::*;
(
    input  wire                 clk_i,
    input  wire axi_ar_t        ar_i,
    input  wire                 ar_valid_i,
    output logic                ar_ready_o,
    output axi_r_t              r_o,
    output logic                r_valid_o,
    input  wire                 r_ready_i,
    input  wire axi_aw_t        aw_i,
    input  wire                 aw_valid_i,
    output logic                aw_ready_o,
    input  wire axi_w_t         w_i,
    input  wire                 w_valid_i,
    output logic                w_ready_o,
    output axi_b_t              b_o,
    output logic                b_valid_o,
    input  wire                 b_ready_i,
    output logic [AXI_ID_W-1:0] ar_id_o,        // Last accepted IDs.
    output logic [AXI_ID_W-1:0] aw_id_o,
    output int                  aw_count_o
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0] mem [0:65535];                 // Word index is address bits 17 to 2.

    task automatic tick();
        @(posedge clk_i);
        #1;
    endtask

    task automatic stall();
        repeat ($urandom_range(0, 3)) tick();
    endtask

    function automatic logic [31:0] beat_addr(input axi_ar_t a, input int beat);
        return (a.burst == BURST_FIXED) ? a.addr : a.addr + 32'(4 * beat);
    endfunction

    // Error window 0x000F_F000 to 0x000F_FFFF.
    function automatic logic [1:0] resp_for(input logic [31:0] addr);
        return (addr[31:12] == 20'h000FF) ? RESP_SLVERR : RESP_OKAY;
    endfunction

    // ==================================================
    // Read channels
    // ==================================================
    initial begin : read_side
        axi_ar_t     ar;
        logic [31:0] addr;
        ar_ready_o = 1'b0;
        r_valid_o  = 1'b0;
        r_o        = '0;
        ar_id_o    = '0;
        forever begin
            tick();
            if (ar_valid_i === 1'b1) begin
                stall();
                ar_ready_o = 1'b1;
                ar         = ar_i;
                tick();                         // AR handshake.
                ar_ready_o = 1'b0;
                ar_id_o    = ar.id;
                for (int i = 0; i <= int'(ar.len); i++) begin
                    stall();
                    addr      = beat_addr(ar, i);
                    r_o.id    = ar.id;
                    r_o.data  = mem[addr[17:2]];
                    r_o.resp  = resp_for(addr);
                    r_o.last  = (i == int'(ar.len));
                    r_valid_o = 1'b1;
                    while (r_ready_i !== 1'b1) tick();
                    tick();
                    r_valid_o = 1'b0;
                end
            end
        end
    end

    // ==================================================
    // Write channels
    // ==================================================
    initial begin : write_side
        axi_aw_t               aw;
        logic [31:0]           addr;
        logic [31:0]           data;
        logic [AXI_STRB_W-1:0] strb;
        logic                  last;
        logic [1:0]            resp;
        aw_ready_o = 1'b0;
        w_ready_o  = 1'b0;
        b_valid_o  = 1'b0;
        b_o        = '0;
        aw_id_o    = '0;
        aw_count_o = 0;
        forever begin
            tick();
            if (aw_valid_i === 1'b1) begin
                stall();
                aw_ready_o = 1'b1;
                aw         = aw_i;
                tick();
                aw_ready_o = 1'b0;
                aw_id_o    = aw.id;
                aw_count_o = aw_count_o + 1;
                resp       = RESP_OKAY;
                last       = 1'b0;
                for (int i = 0; !last; i++) begin
                    stall();
                    w_ready_o = 1'b1;
                    while (w_valid_i !== 1'b1) tick();
                    addr = beat_addr(aw, i);
                    data = w_i.data;
                    strb = w_i.strb;
                    last = w_i.last;
                    tick();                     // W handshake.
                    w_ready_o = 1'b0;
                    for (int b = 0; b < AXI_STRB_W; b++) begin
                        if (strb[b]) begin
                            mem[addr[17:2]][8*b +: 8] = data[8*b +: 8];   // Byte lanes.
                        end
                    end
                    resp = resp | resp_for(addr);
                end
                stall();
                b_o.id    = aw.id;
                b_o.resp  = resp;
                b_valid_o = 1'b1;
                while (b_ready_i !== 1'b1) tick();
                tick();
                b_valid_o = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/dmac_top.sv ====
`default_nettype none

module dmac_top
    import dma_axi_pkg::*;
    import dma_cfg_pkg::*;
#(
    parameter int NUM_BEATS = 16
) (
    input  wire            clk_i,
    input  wire            rst_ni,

    input  wire            start_i,
    input  wire dma_desc_t desc_i,
    output logic           busy_o,
    output logic           done_o,
    output logic           err_o,

    output axi_ar_t        ar_o,
    output logic           ar_valid_o,
    input  wire            ar_ready_i,
    input  wire axi_r_t    r_i,
    input  wire            r_valid_i,
    output logic           r_ready_o,

    output axi_aw_t        aw_o,
    output logic           aw_valid_o,
    input  wire            aw_ready_i,
    output axi_w_t         w_o,
    output logic           w_valid_o,
    input  wire            w_ready_i,
    input  wire axi_b_t    b_i,
    input  wire            b_valid_i,
    output logic           b_ready_o
);

    logic                                 rd_start;
    logic                                 rd_done;
    logic                                 rd_err;
    logic                                 wr_start;
    logic                                 wr_done;
    logic                                 wr_err;
    dma_desc_t                            desc;
    logic [NUM_BEATS-1:0][AXI_DATA_W-1:0] line;       // Read to write buffer.

    dmac_ctrl u_ctrl (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .start_i    (start_i),
        .desc_i     (desc_i),
        .rd_done_i  (rd_done),
        .rd_err_i   (rd_err),
        .wr_done_i  (wr_done),
        .wr_err_i   (wr_err),
        .rd_start_o (rd_start),
        .wr_start_o (wr_start),
        .desc_o     (desc),
        .busy_o     (busy_o),
        .done_o     (done_o),
        .err_o      (err_o)
    );

    dmac_read #(
        .NUM_BEATS (NUM_BEATS)
    ) u_read (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .start_i    (rd_start),
        .desc_i     (desc),
        .ar_o       (ar_o),
        .ar_valid_o (ar_valid_o),
        .ar_ready_i (ar_ready_i),
        .r_i        (r_i),
        .r_valid_i  (r_valid_i),
        .r_ready_o  (r_ready_o),
        .line_o     (line),
        .done_o     (rd_done),
        .err_o      (rd_err)
    );

    dmac_write #(
        .NUM_BEATS (NUM_BEATS)
    ) u_write (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .start_i    (wr_start),
        .desc_i     (desc),
        .line_i     (line),
        .aw_o       (aw_o),
        .aw_valid_o (aw_valid_o),
        .aw_ready_i (aw_ready_i),
        .w_o        (w_o),
        .w_valid_o  (w_valid_o),
        .w_ready_i  (w_ready_i),
        .b_i        (b_i),
        .b_valid_i  (b_valid_i),
        .b_ready_o  (b_ready_o),
        .done_o     (wr_done),
        .err_o      (wr_err)
    );

endmodule

`default_nettype wire

// ==== hdl/dmac_write.sv ====
`default_nettype none

module dmac_write
    import dma_axi_pkg::*;
    import dma_cfg_pkg::*;
#(
    parameter int NUM_BEATS = 16
) (
    input  wire                                  clk_i,
    input  wire                                  rst_ni,

    input  wire                                  start_i,
    input  wire dma_desc_t                       desc_i,
    input  wire [NUM_BEATS-1:0][AXI_DATA_W-1:0]  line_i,

    output axi_aw_t                              aw_o,
    output logic                                 aw_valid_o,
    input  wire                                  aw_ready_i,

    output axi_w_t                               w_o,
    output logic                                 w_valid_o,
    input  wire                                  w_ready_i,

    input  wire axi_b_t                          b_i,
    input  wire                                  b_valid_i,
    output logic                                 b_ready_o,

    output logic                                 done_o,
    output logic                                 err_o
);

    localparam int BEAT_W = $clog2(NUM_BEATS);

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_RESP
    } wr_state_e;

    wr_state_e         state_q;
    axi_aw_t           aw_q;
    logic [BEAT_W-1:0] beat_q;
    logic              last_beat;
    logic              w_fire;
    logic              b_fire;

    assign last_beat = (beat_q == aw_q.len[BEAT_W-1:0]);
    assign w_fire    = w_valid_o && w_ready_i;
    assign b_fire    = b_valid_i && b_ready_o;

    // ==================================================
    // Sequencing
    // ==================================================
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q <= WR_IDLE;
            beat_q  <= '0;
            done_o  <= 1'b0;
            err_o   <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state_q)
                WR_IDLE: begin
                    if (start_i) begin
                        state_q <= WR_ADDR;
                    end
                end
                WR_ADDR: begin
                    beat_q <= '0;
                    if (aw_valid_o && aw_ready_i) begin
                        state_q <= WR_DATA;
                    end
                end
                WR_DATA: begin
                    if (w_fire) begin
                        beat_q <= beat_q + BEAT_W'(1);
                        if (last_beat) begin
                            state_q <= WR_RESP;
                        end
                    end
                end
                WR_RESP: begin
                    if (b_fire) begin
                        state_q <= WR_IDLE;
                        done_o  <= 1'b1;
                        err_o   <= (b_i.resp != RESP_OKAY);
                    end
                end
                default: state_q <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == WR_IDLE && start_i) begin
            aw_q.id    <= region_id(desc_i.dst_addr);
            aw_q.addr  <= desc_i.dst_addr;
            aw_q.len   <= desc_i.len;
            aw_q.burst <= desc_i.burst;
        end
    end

    assign aw_o       = aw_q;
    assign aw_valid_o = (state_q == WR_ADDR);

    assign w_o.data   = line_i[beat_q];
    assign w_o.strb   = '1;                             // Full words only.
    assign w_o.last   = last_beat;
    assign w_valid_o  = (state_q == WR_DATA);

    assign b_ready_o  = (state_q == WR_RESP);

endmodule

`default_nettype wire

// ==== hdl/dmac_read.sv ====
`default_nettype none

module dmac_read
    import dma_axi_pkg::*;
    import dma_cfg_pkg::*;
#(
    parameter int NUM_BEATS = 16
) (
    input  wire                                  clk_i,
    input  wire                                  rst_ni,

    input  wire                                  start_i,
    input  wire dma_desc_t                       desc_i,

    output axi_ar_t                              ar_o,
    output logic                                 ar_valid_o,
    input  wire                                  ar_ready_i,

    input  wire axi_r_t                          r_i,
    input  wire                                  r_valid_i,
    output logic                                 r_ready_o,

    output logic [NUM_BEATS-1:0][AXI_DATA_W-1:0] line_o,
    output logic                                 done_o,
    output logic                                 err_o
);

    localparam int BEAT_W = $clog2(NUM_BEATS);

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA
    } rd_state_e;

    rd_state_e         state_q;
    axi_ar_t           ar_q;
    logic [BEAT_W-1:0] beat_q;
    logic              err_q;
    logic              ar_fire;
    logic              r_fire;

    assign ar_fire = ar_valid_o && ar_ready_i;
    assign r_fire  = r_valid_i && r_ready_o;

    // ==================================================
    // Sequencing
    // ==================================================
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q <= RD_IDLE;
            done_o  <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state_q)
                RD_IDLE: begin
                    if (start_i) begin
                        state_q <= RD_ADDR;
                    end
                end
                RD_ADDR: begin
                    if (ar_fire) begin
                        state_q <= RD_DATA;
                    end
                end
                RD_DATA: begin
                    if (r_fire && r_i.last) begin
                        state_q <= RD_IDLE;
                        done_o  <= 1'b1;                // One cycle after the last beat.
                    end
                end
                default: state_q <= RD_IDLE;
            endcase
        end
    end

    // Request is held while AR waits for ready.
    always_ff @(posedge clk_i) begin
        if (state_q == RD_IDLE && start_i) begin
            ar_q.id    <= region_id(desc_i.src_addr);
            ar_q.addr  <= desc_i.src_addr;
            ar_q.len   <= desc_i.len;
            ar_q.burst <= desc_i.burst;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            beat_q <= '0;
            err_q  <= 1'b0;
        end else if (state_q == RD_ADDR) begin
            beat_q <= '0;
            err_q  <= 1'b0;
        end else if (r_fire) begin
            beat_q <= beat_q + BEAT_W'(1);
            if (r_i.resp != RESP_OKAY) begin
                err_q <= 1'b1;                          // Sticky for the burst.
            end
        end
    end

    // Line buffer.
    always_ff @(posedge clk_i) begin
        if (r_fire) begin
            line_o[beat_q] <= r_i.data;
        end
    end

    assign ar_o       = ar_q;
    assign ar_valid_o = (state_q == RD_ADDR);
    assign r_ready_o  = (state_q == RD_DATA);
    assign err_o      = err_q;

endmodule

`default_nettype wire

// ==== hdl/dmac_ctrl.sv ====
`default_nettype none

module dmac_ctrl
    import dma_cfg_pkg::*;
(
    input  wire            clk_i,
    input  wire            rst_ni,

    input  wire            start_i,
    input  wire dma_desc_t desc_i,

    input  wire            rd_done_i,
    input  wire            rd_err_i,
    input  wire            wr_done_i,
    input  wire            wr_err_i,

    output logic           rd_start_o,
    output logic           wr_start_o,
    output dma_desc_t      desc_o,

    output logic           busy_o,
    output logic           done_o,
    output logic           err_o
);

    typedef enum logic [1:0] {
        CT_IDLE,
        CT_READ,
        CT_WRITE
    } ctrl_state_e;

    ctrl_state_e state_q;
    logic        rd_err_q;
    logic        accept;

    assign accept = (state_q == CT_IDLE) && start_i;   // Busy starts are dropped.

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q    <= CT_IDLE;
            rd_start_o <= 1'b0;
            rd_err_q   <= 1'b0;
            done_o     <= 1'b0;
            err_o      <= 1'b0;
        end else begin
            rd_start_o <= accept;
            done_o     <= 1'b0;
            case (state_q)
                CT_IDLE: begin
                    if (accept) begin
                        state_q <= CT_READ;
                    end
                end
                CT_READ: begin
                    if (rd_done_i) begin
                        state_q  <= CT_WRITE;
                        rd_err_q <= rd_err_i;
                    end
                end
                CT_WRITE: begin
                    if (wr_done_i) begin
                        state_q <= CT_IDLE;
                        done_o  <= 1'b1;
                        err_o   <= rd_err_q | wr_err_i;
                    end
                end
                default: state_q <= CT_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            desc_o <= desc_i;
        end
    end

    assign wr_start_o = (state_q == CT_READ) && rd_done_i;
    assign busy_o     = (state_q != CT_IDLE);

endmodule

`default_nettype wire

// ==== hdl/dma_cfg_pkg.sv ====
`default_nettype none

package dma_cfg_pkg;

    import dma_axi_pkg::*;

    typedef struct packed {
        logic [AXI_ADDR_W-1:0] src_addr;
        logic [AXI_ADDR_W-1:0] dst_addr;
        logic [7:0]            len;      // Beats minus one.
        logic [1:0]            burst;
    } dma_desc_t;

    // ==================================================
    // Address regions and their transaction IDs
    // ==================================================
    localparam logic [3:0] REGION_MEM = 4'h0;
    localparam logic [3:0] REGION_AES = 4'h2;

    localparam logic [AXI_ID_W-1:0] ID_DMA2MEM = 4'd1;
    localparam logic [AXI_ID_W-1:0] ID_DMA2AES = 4'd2;

    // Region sits in address bits 19 to 16.
    function automatic logic [AXI_ID_W-1:0] region_id(input logic [AXI_ADDR_W-1:0] addr);
        case (addr[19:16])
            REGION_MEM: return ID_DMA2MEM;
            REGION_AES: return ID_DMA2AES;
            default:    return '0;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== hdl/dma_axi_pkg.sv ====
`default_nettype none

package dma_axi_pkg;

    // ==================================================
    // Bus widths
    // ==================================================
    localparam int AXI_ID_W   = 4;
    localparam int AXI_ADDR_W = 32;
    localparam int AXI_DATA_W = 32;
    localparam int AXI_STRB_W = AXI_DATA_W / 8;

    localparam logic [1:0] BURST_FIXED = 2'b00;
    localparam logic [1:0] BURST_INCR  = 2'b01;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // ==================================================
    // Channel payloads
    // ==================================================
    typedef struct packed {
        logic [AXI_ID_W-1:0]   id;
        logic [AXI_ADDR_W-1:0] addr;
        logic [7:0]            len;      // Beats minus one.
        logic [1:0]            burst;
    } axi_ar_t;

    typedef axi_ar_t axi_aw_t;           // Same fields as the read address.

    typedef struct packed {
        logic [AXI_ID_W-1:0]   id;
        logic [AXI_DATA_W-1:0] data;
        logic [1:0]            resp;
        logic                  last;
    } axi_r_t;

    typedef struct packed {
        logic [AXI_DATA_W-1:0] data;
        logic [AXI_STRB_W-1:0] strb;
        logic                  last;
    } axi_w_t;

    typedef struct packed {
        logic [AXI_ID_W-1:0] id;
        logic [1:0]          resp;
    } axi_b_t;

endpackage

`default_nettype wire
